// ==== list.f ====
+incdir+test
hdl/exec_pkg.sv
hdl/alu.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/stage_reg.sv
hdl/exec_unit.sv
test/tb_exec_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_exec_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_ref_model.svh ====
logic [31:0] mirror [32];  // Architectural registers in program order

// Xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// R-type field order, I and B words reuse it
function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

// Expected {is_branch, rd, data} of one instruction, commits to the mirror
function automatic logic [37:0] model_exec(input logic [31:0] instr, input logic [31:0] pc);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  logic [4:0]  rd;
  logic        br;
  logic        lt;
  logic        ltu;
  logic        c;
  a = mirror[instr[19:15]];
  if (instr[6:0] == exec_pkg::OPC_OP_IMM) begin
    b = {{20{instr[31]}}, instr[31:20]};
  end else begin
    b = mirror[instr[24:20]];
  end
  lt  = $signed(a) < $signed(b);
  ltu = a < b;
  rd  = instr[11:7];
  br  = 1'b0;
  r   = '0;
  c   = 1'b0;
  case (instr[6:0])
    exec_pkg::OPC_OP, exec_pkg::OPC_OP_IMM: begin
      case (instr[14:12])
        3'd0: r = (instr[5] && instr[30]) ? a - b : a + b;  // SUB only in register form
        3'd1: r = a << b[4:0];
        3'd2: r = {31'd0, lt};
        3'd3: r = {31'd0, ltu};
        3'd4: r = a ^ b;
        3'd5: r = instr[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    exec_pkg::OPC_LUI:   r = {instr[31:12], 12'd0};
    exec_pkg::OPC_AUIPC: r = pc + {instr[31:12], 12'd0};
    exec_pkg::OPC_JAL, exec_pkg::OPC_JALR: r = pc + 32'd4;
    exec_pkg::OPC_BRANCH: begin
      case (instr[14:12])
        3'd0: c = (a == b);
        3'd1: c = (a != b);
        3'd4: c = lt;
        3'd5: c = !lt;
        3'd6: c = ltu;
        default: c = !ltu;
      endcase
      r  = {31'd0, c};
      rd = 5'd0;
      br = 1'b1;
    end
    default: rd = 5'd0;
  endcase
  if (!br && rd != 5'd0) begin
    mirror[rd] = r;
  end
  return {br, rd, r};
endfunction

// ==== test/tb_exec_unit.sv ====
`timescale 1ns/10ps

module tb_exec_unit;

  localparam int RANDOM_INSTRS = 400;
  localparam int MAX_WAIT      = 200;  // Cycles before any wait gives up

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] in_instr;
  logic [31:0] in_pc;
  logic        in_ready;
  logic        out_valid;
  logic [4:0]  out_rd;
  logic [31:0] out_data;
  logic        out_is_branch;
  logic        out_taken;
  logic        out_ready;

  logic [37:0] expected [1024];  // Scoreboard in program order
  logic [9:0]  wr_ptr = '0;
  logic [9:0]  rd_ptr = '0;
  logic [9:0]  acc_cnt = '0;     // Accepted instructions
  logic [31:0] rnd;
  logic        backpressure;
  logic        ready_exp;

  `include "tb_ref_model.svh"

  exec_unit exec_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (in_valid && in_ready) acc_cnt <= acc_cnt + 10'd1;
    if (out_valid && out_ready) rd_ptr <= rd_ptr + 10'd1;
  end

  // Two in flight with the output stalled means stage X is occupied
  assign ready_exp = !(out_valid && !out_ready && (acc_cnt - rd_ptr) > 10'd1);

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    fail_run($sformatf("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  check_data : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_data == expected[rd_ptr][31:0])
    else mismatch("out_data", $sampled(out_data), $sampled(expected[rd_ptr][31:0]));

  check_rd : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_rd == expected[rd_ptr][36:32])
    else mismatch("out_rd", 32'($sampled(out_rd)), 32'($sampled(expected[rd_ptr][36:32])));

  check_branch : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_is_branch == expected[rd_ptr][37])
    else mismatch("out_is_branch", 32'($sampled(out_is_branch)),
                  32'($sampled(expected[rd_ptr][37])));

  check_taken : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_taken == (expected[rd_ptr][37] && expected[rd_ptr][0]))
    else mismatch("out_taken", 32'($sampled(out_taken)),
                  32'($sampled(expected[rd_ptr][37] && expected[rd_ptr][0])));

  check_ready : assert property (@(posedge clk) disable iff (rst) in_ready == ready_exp)
    else mismatch("in_ready", 32'($sampled(in_ready)), 32'($sampled(ready_exp)));

  no_extra_output : assert property (@(posedge clk) disable iff (rst)
    out_valid |-> rd_ptr < wr_ptr)
    else fail_run("output presented with no instruction outstanding");

  output_held : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable({out_rd, out_data, out_is_branch}))
    else fail_run("output changed or vanished while out_ready was low");

  task automatic next_cycle();
    @(posedge clk);
    #1;
    rnd = xorshift32(rnd);
    out_ready = backpressure ? (rnd[9:8] != 2'b00) : 1'b1;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (mirror[i]) mirror[i] = '0;
  endtask

  // Holds the instruction on the input until it is taken
  task automatic issue(input logic [31:0] instr);
    int          waited;
    logic        took;
    logic [31:0] pc;
    rnd = xorshift32(rnd);
    pc = {rnd[31:2], 2'b00};
    expected[wr_ptr] = model_exec(instr, pc);
    wr_ptr = wr_ptr + 10'd1;
    in_valid = 1'b1;
    in_instr = instr;
    in_pc = pc;
    waited = 0;
    do begin
      @(negedge clk);
      took = in_ready;
      next_cycle();
      waited++;
      if (!took && waited > MAX_WAIT) fail_run("timeout waiting for in_ready");
    end while (!took);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (rd_ptr != wr_ptr) begin
      next_cycle();
      waited++;
      if (waited > MAX_WAIT) fail_run("timeout waiting for the pipeline to drain");
    end
  endtask

  task automatic read_all_regs();
    for (int i = 1; i < 32; i++) begin
      issue(encode(7'd0, 5'd0, 5'(i), 3'd0, 5'd0, exec_pkg::OPC_OP));  // add x0, xi, x0
    end
  endtask

  function automatic logic [31:0] random_instr(input logic [31:0] r, input logic [31:0] s);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] instr;
    rd  = {2'b00, r[2:0]};  // x0 to x7 for dense dependencies
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    alt = r[16] && (f3 == 3'd0 || f3 == 3'd5);
    case (r[15:12])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
        instr = encode({1'b0, alt, 5'd0}, rs2, rs1, f3, rd, exec_pkg::OPC_OP);
      4'd5, 4'd6, 4'd7, 4'd8: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          instr = encode({1'b0, alt, 5'd0}, s[4:0], rs1, f3, rd, exec_pkg::OPC_OP_IMM);
        end else begin
          instr = encode(s[11:5], s[4:0], rs1, f3, rd, exec_pkg::OPC_OP_IMM);
        end
      end
      4'd9:  instr = {s[31:12], rd, exec_pkg::OPC_LUI};
      4'd10: instr = {s[31:12], rd, exec_pkg::OPC_AUIPC};
      4'd11: instr = {s[31:12], rd, exec_pkg::OPC_JAL};
      4'd12: instr = encode(s[11:5], s[4:0], rs1, 3'd0, rd, exec_pkg::OPC_JALR);
      default: begin
        if (f3[2:1] == 2'b01) f3 = {2'b10, f3[0]};  // No reserved branch funct3
        instr = encode(s[11:5], rs2, rs1, f3, s[4:0], exec_pkg::OPC_BRANCH);
      end
    endcase
    return instr;
  endfunction

  initial begin
    logic [31:0] word;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    out_ready = 1'b1;
    backpressure = 1'b0;
    rnd = 32'hb23;
    apply_reset();
    read_all_regs();
    issue(encode(7'h7f, 5'h1f, 5'd0, 3'd0, 5'd0, exec_pkg::OPC_OP_IMM));  // addi x0, x0, -1
    issue(encode(7'd0, 5'd0, 5'd0, 3'd0, 5'd1, exec_pkg::OPC_OP));        // x0 not forwarded
    // Sign boundary values, each one forwarded into the next
    issue({20'h80000, 5'd1, exec_pkg::OPC_LUI});
    issue(encode(7'h7f, 5'h1f, 5'd1, 3'd0, 5'd2, exec_pkg::OPC_OP_IMM));  // x2 = 0x7fffffff
    issue(encode(7'h7f, 5'h1f, 5'd0, 3'd0, 5'd3, exec_pkg::OPC_OP_IMM));  // x3 = -1
    issue(encode(7'd0, 5'd2, 5'd3, 3'd0, 5'd4, exec_pkg::OPC_OP));        // From X and wb_q
    for (int alt = 0; alt < 2; alt++) begin
      for (int k = 0; k < 8; k++) begin
        issue(encode({1'b0, alt == 1 && (k == 0 || k == 5), 5'd0}, 5'd3, 5'd1, 3'(k), 5'd5,
                     exec_pkg::OPC_OP));
      end
    end
    // Signed and unsigned order disagree on x1 and x2, then equal operands
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 8; k++) begin
        if (k != 2 && k != 3) begin
          issue(encode(7'd0, 5'd2, p == 0 ? 5'd1 : 5'd2, 3'(k), 5'd1, exec_pkg::OPC_BRANCH));
        end
      end
    end
    issue(encode(7'd0, 5'd0, 5'd1, 3'd0, 5'd0, exec_pkg::OPC_OP));  // x1 still old value
    for (int n = 0; n < RANDOM_INSTRS; n++) begin
      backpressure = (n >= RANDOM_INSTRS / 2);
      rnd = xorshift32(rnd);
      word = rnd;
      rnd = xorshift32(rnd);
      issue(random_instr(word, rnd));
    end
    drain();
    backpressure = 1'b0;
    apply_reset();
    read_all_regs();  // Registers held values before this reset
    drain();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  input  logic [31:0]                         in_instr,
  input  logic [exec_pkg::XLEN-1:0]           in_pc,
  output logic                                in_ready,
  output logic                                out_valid,
  output logic [exec_pkg::REG_ADDR_WIDTH-1:0] out_rd,
  output logic [exec_pkg::XLEN-1:0]           out_data,
  output logic                                out_is_branch,
  output logic                                out_taken,
  input  logic                                out_ready
);

  // Operands already selected and forwarded in stage D
  typedef struct packed {
    logic [exec_pkg::XLEN-1:0]           a;
    logic [exec_pkg::XLEN-1:0]           b;
    exec_pkg::alu_op_t                   op;
    logic [exec_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic                                is_branch;
  } ex_payload_t;

  typedef struct packed {
    logic [exec_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [exec_pkg::XLEN-1:0]           result;
    logic                                is_branch;
  } wb_payload_t;

  exec_pkg::alu_op_t                   d_op;
  logic [exec_pkg::REG_ADDR_WIDTH-1:0] d_rs1;
  logic [exec_pkg::REG_ADDR_WIDTH-1:0] d_rs2;
  logic [exec_pkg::REG_ADDR_WIDTH-1:0] d_rd;
  logic [exec_pkg::XLEN-1:0]           d_imm;
  logic                                d_a_is_pc;
  logic                                d_b_is_imm;
  logic                                d_is_branch;
  logic [exec_pkg::XLEN-1:0]           rf_rdata1;
  logic [exec_pkg::XLEN-1:0]           rf_rdata2;
  logic                                rf_we;
  logic [exec_pkg::XLEN-1:0]           fwd_rs1;
  logic [exec_pkg::XLEN-1:0]           fwd_rs2;
  logic [exec_pkg::XLEN-1:0]           x_result;
  ex_payload_t                         ex_in;
  ex_payload_t                         ex_data;
  wb_payload_t                         wb_in;
  wb_payload_t                         wb_data;
  logic                                ex_valid;
  logic                                ex_hold;
  logic                                wb_valid;
  logic                                wb_hold;

  // Youngest producer wins, x0 never matches
  function automatic logic [exec_pkg::XLEN-1:0] forward(
    input logic [exec_pkg::REG_ADDR_WIDTH-1:0] addr,
    input logic [exec_pkg::XLEN-1:0]           rf_val,
    input logic                                x_hit_valid,
    input logic [exec_pkg::REG_ADDR_WIDTH-1:0] x_rd,
    input logic [exec_pkg::XLEN-1:0]           x_val,
    input logic                                w_hit_valid,
    input logic [exec_pkg::REG_ADDR_WIDTH-1:0] w_rd,
    input logic [exec_pkg::XLEN-1:0]           w_val
  );
    logic [exec_pkg::XLEN-1:0] val;
    val = rf_val;
    if (w_hit_valid && w_rd != '0 && w_rd == addr) val = w_val;  // Not yet committed
    if (x_hit_valid && x_rd != '0 && x_rd == addr) val = x_val;
    return val;
  endfunction

  inst_decoder u_dec (
    .instr     (in_instr),
    .op        (d_op),
    .rs1       (d_rs1),
    .rs2       (d_rs2),
    .rd        (d_rd),
    .imm       (d_imm),
    .a_is_pc   (d_a_is_pc),
    .b_is_imm  (d_b_is_imm),
    .is_branch (d_is_branch)
  );

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (d_rs1),
    .raddr2 (d_rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .we     (rf_we),
    .waddr  (out_rd),
    .wdata  (out_data)
  );

  assign fwd_rs1 = forward(d_rs1, rf_rdata1, ex_valid, ex_data.rd, x_result,
                           wb_valid, wb_data.rd, wb_data.result);
  assign fwd_rs2 = forward(d_rs2, rf_rdata2, ex_valid, ex_data.rd, x_result,
                           wb_valid, wb_data.rd, wb_data.result);

  always_comb begin
    ex_in.a         = d_a_is_pc ? in_pc : fwd_rs1;
    ex_in.b         = d_b_is_imm ? d_imm : fwd_rs2;
    ex_in.op        = d_op;
    ex_in.rd        = d_rd;
    ex_in.is_branch = d_is_branch;
  end

  // Stall chain runs back from the sink
  assign wb_hold  = wb_valid && !out_ready;
  assign ex_hold  = ex_valid && wb_hold;
  assign in_ready = !ex_hold;

  stage_reg #(.payload_t(ex_payload_t)) ex_q (
    .clk       (clk),
    .rst       (rst),
    .hold      (ex_hold),
    .in_valid  (in_valid && in_ready),
    .in_data   (ex_in),
    .out_valid (ex_valid),
    .out_data  (ex_data)
  );

  alu #(.WIDTH(exec_pkg::XLEN)) u_alu (
    .a      (ex_data.a),
    .b      (ex_data.b),
    .op     (ex_data.op),
    .result (x_result)
  );

  always_comb begin
    wb_in.rd        = ex_data.rd;
    wb_in.result    = x_result;
    wb_in.is_branch = ex_data.is_branch;
  end

  stage_reg #(.payload_t(wb_payload_t)) wb_q (
    .clk       (clk),
    .rst       (rst),
    .hold      (wb_hold),
    .in_valid  (ex_valid),
    .in_data   (wb_in),
    .out_valid (wb_valid),
    .out_data  (wb_data)
  );

  assign out_valid     = wb_valid;
  assign out_rd        = wb_data.rd;
  assign out_data      = wb_data.result;  // Compare flag for branches
  assign out_is_branch = wb_data.is_branch;
  assign out_taken     = wb_data.is_branch && wb_data.result[0];

  // Commit on the output transfer
  assign rf_we = out_valid && out_ready && !out_is_branch && out_rd != '0;

endmodule

// ==== hdl/stage_reg.sv ====
`timescale 1ns/10ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      out_data <= in_data;  // Advances together with valid
    end
  end

  // A stalled stage keeps presenting the same payload
  hold_stable : assert property (@(posedge clk) disable iff (rst)
    hold && out_valid |=> $stable(out_data))
    else $error("stage_reg: payload changed while held");

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [exec_pkg::REG_ADDR_WIDTH-1:0] raddr1,
  input  logic [exec_pkg::REG_ADDR_WIDTH-1:0] raddr2,
  output logic [exec_pkg::XLEN-1:0]           rdata1,
  output logic [exec_pkg::XLEN-1:0]           rdata2,
  input  logic                                we,
  input  logic [exec_pkg::REG_ADDR_WIDTH-1:0] waddr,
  input  logic [exec_pkg::XLEN-1:0]           wdata
);

  // x1 to x31, x0 has no storage
  logic [exec_pkg::XLEN-1:0] regs [1:(2**exec_pkg::REG_ADDR_WIDTH)-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 2**exec_pkg::REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Old value during a same-cycle write
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // Writeback gating upstream keeps x0 out of the write port
  no_x0_write : assert property (@(posedge clk) disable iff (rst) we |-> waddr != '0)
    else $error("reg_file: write to x0 requested");

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
  input  logic [31:0]                         instr,
  output exec_pkg::alu_op_t                   op,
  output logic [exec_pkg::REG_ADDR_WIDTH-1:0] rs1,
  output logic [exec_pkg::REG_ADDR_WIDTH-1:0] rs2,
  output logic [exec_pkg::REG_ADDR_WIDTH-1:0] rd,
  output logic [exec_pkg::XLEN-1:0]           imm,
  output logic                                a_is_pc,
  output logic                                b_is_imm,
  output logic                                is_branch
);

  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic                       alt;       // instr[30], SUB and SRA
  logic [exec_pkg::XLEN-1:0]  imm_i;
  logic [exec_pkg::XLEN-1:0]  imm_u;
  logic [exec_pkg::XLEN-1:0]  imm_j;
  logic [exec_pkg::XLEN-1:0]  imm_b;
  exec_pkg::alu_op_t          arith_op;  // Shared by OP and OP_IMM

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    case (funct3)
      exec_pkg::F3_ADD_SUB:
        arith_op = (alt && opcode == exec_pkg::OPC_OP) ? exec_pkg::OP_SUB : exec_pkg::OP_ADD;
      exec_pkg::F3_SLL:  arith_op = exec_pkg::OP_SLL;
      exec_pkg::F3_SLT:  arith_op = exec_pkg::OP_SLT;
      exec_pkg::F3_SLTU: arith_op = exec_pkg::OP_SLTU;
      exec_pkg::F3_XOR:  arith_op = exec_pkg::OP_XOR;
      exec_pkg::F3_SR:   arith_op = alt ? exec_pkg::OP_SRA : exec_pkg::OP_SRL;
      exec_pkg::F3_OR:   arith_op = exec_pkg::OP_OR;
      default:           arith_op = exec_pkg::OP_AND;
    endcase
  end

  always_comb begin
    op        = exec_pkg::OP_ADD;
    rd        = instr[11:7];
    imm       = imm_i;
    a_is_pc   = 1'b0;
    b_is_imm  = 1'b0;
    is_branch = 1'b0;
    case (opcode)
      exec_pkg::OPC_OP: op = arith_op;
      exec_pkg::OPC_OP_IMM: begin
        op       = arith_op;
        b_is_imm = 1'b1;  // shamt sits in imm[4:0]
      end
      exec_pkg::OPC_LUI: begin
        op       = exec_pkg::OP_PASSB;
        imm      = imm_u;
        b_is_imm = 1'b1;
      end
      exec_pkg::OPC_AUIPC: begin
        imm      = imm_u;
        a_is_pc  = 1'b1;
        b_is_imm = 1'b1;
      end
      exec_pkg::OPC_JAL: begin
        op      = exec_pkg::OP_ADD4A;  // Link value pc + 4
        imm     = imm_j;
        a_is_pc = 1'b1;
      end
      exec_pkg::OPC_JALR: begin
        op      = exec_pkg::OP_ADD4A;
        a_is_pc = 1'b1;
      end
      exec_pkg::OPC_BRANCH: begin
        imm       = imm_b;
        rd        = '0;    // No register write
        is_branch = 1'b1;
        case (funct3)
          exec_pkg::F3_BEQ:  op = exec_pkg::OP_EQ;
          exec_pkg::F3_BNE:  op = exec_pkg::OP_NEQ;
          exec_pkg::F3_BLT:  op = exec_pkg::OP_SLT;
          exec_pkg::F3_BGE:  op = exec_pkg::OP_SGTE;
          exec_pkg::F3_BLTU: op = exec_pkg::OP_SLTU;
          exec_pkg::F3_BGEU: op = exec_pkg::OP_SGTEU;
          default:           is_branch = 1'b0;  // Reserved, becomes ADD to x0
        endcase
      end
      default: rd = '0;  // Unsupported opcode has no effect
    endcase
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu #(
  parameter int WIDTH = exec_pkg::XLEN
) (
  input  logic [WIDTH-1:0]  a,
  input  logic [WIDTH-1:0]  b,
  input  exec_pkg::alu_op_t op,
  output logic [WIDTH-1:0]  result
);

  logic [WIDTH-1:0]         b_in;       // Second adder operand
  logic                     carry_in;   // Set for subtract and less-than
  logic [WIDTH-1:0]         sum;
  logic                     carry_out;  // High when a >= b unsigned
  logic [WIDTH-1:0]         xor_ab;
  logic                     lt_signed;
  logic                     cmp;
  logic [$clog2(WIDTH)-1:0] shamt;

  assign xor_ab = a ^ b;
  assign shamt  = b[$clog2(WIDTH)-1:0];  // Upper shift bits ignored

  // Adder operand setup
  always_comb begin
    case (op)
      exec_pkg::OP_SUB,
      exec_pkg::OP_SLT,
      exec_pkg::OP_SGTE,
      exec_pkg::OP_SLTU,
      exec_pkg::OP_SGTEU: begin
        b_in     = ~b;
        carry_in = 1'b1;
      end
      exec_pkg::OP_ADD4A: begin
        b_in     = {{(WIDTH-3){1'b0}}, 3'd4};
        carry_in = 1'b0;
      end
      default: begin
        b_in     = b;
        carry_in = 1'b0;
      end
    endcase
  end

  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_in} + {{WIDTH{1'b0}}, carry_in};

  // Differing signs settle it, otherwise sign of the difference
  assign lt_signed = (a[WIDTH-1] != b[WIDTH-1]) ? a[WIDTH-1] : sum[WIDTH-1];

  always_comb begin
    case (op)
      exec_pkg::OP_EQ:    cmp = ~|xor_ab;
      exec_pkg::OP_NEQ:   cmp = |xor_ab;
      exec_pkg::OP_SLT:   cmp = lt_signed;
      exec_pkg::OP_SGTE:  cmp = ~lt_signed;
      exec_pkg::OP_SLTU:  cmp = ~carry_out;  // Borrow means a < b
      exec_pkg::OP_SGTEU: cmp = carry_out;
      default:            cmp = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      exec_pkg::OP_AND:   result = a & b;
      exec_pkg::OP_OR:    result = a | b;
      exec_pkg::OP_XOR:   result = xor_ab;
      exec_pkg::OP_SLL:   result = a << shamt;
      exec_pkg::OP_SRL:   result = a >> shamt;
      exec_pkg::OP_SRA:   result = $signed(a) >>> shamt;
      exec_pkg::OP_PASSB: result = b;
      exec_pkg::OP_EQ,
      exec_pkg::OP_NEQ,
      exec_pkg::OP_SLT,
      exec_pkg::OP_SGTE,
      exec_pkg::OP_SLTU,
      exec_pkg::OP_SGTEU: result = {{(WIDTH-1){1'b0}}, cmp};  // Zero-extended flag
      default:            result = sum;                       // ADD, SUB, ADD4A
    endcase
  end

  // Known operands must give a known result once the step settles
  always_comb begin
    if (!$isunknown({a, b, op})) begin
      assert final (!$isunknown(result))
        else $error("alu: unknown result for op %0d", op);
    end
  end

endmodule

// ==== hdl/exec_pkg.sv ====
package exec_pkg;

  localparam int XLEN           = 32;  // Datapath width
  localparam int ALU_OP_WIDTH   = 5;
  localparam int REG_ADDR_WIDTH = 5;   // x0 to x31

  // ALU operations
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_AND   = 5'd2,
    OP_OR    = 5'd3,
    OP_XOR   = 5'd4,
    OP_SLL   = 5'd5,
    OP_SRL   = 5'd6,
    OP_SRA   = 5'd7,
    OP_PASSB = 5'd8,   // LUI
    OP_ADD4A = 5'd9,   // Link address, a plus 4
    OP_EQ    = 5'd10,
    OP_NEQ   = 5'd11,
    OP_SLT   = 5'd12,
    OP_SGTE  = 5'd13,
    OP_SLTU  = 5'd14,
    OP_SGTEU = 5'd15
  } alu_op_t;

  // RV32I major opcodes in instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;  // SRL or SRA by bit 30
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
